// ==== hw/i2c_master_params.svh ====
`ifndef I2C_MASTER_PARAMS_SVH
`define I2C_MASTER_PARAMS_SVH

// i2c_clk cycles per quarter of an SCL period
// One bit on the bus lasts four quarters
`define I2C_QTR_DIV 4

// Width of the read length field
// The field holds the byte count minus one
`define I2C_RD_LEN_W 2

`endif

// ==== hw/i2c_master_pkg.sv ====
`include "i2c_master_params.svh"

package i2c_master_pkg;

    // Controller states
    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        ADDR_ACK,
        WRITE,
        WRITE_ACK,
        READ,
        READ_ACK,
        STOP,
        HOLD
    } i2c_state_e;

    // User command, sampled on start_i
    typedef struct packed {
        logic [6:0]               addr;
        logic                     rw;
        logic [7:0]               wdata;
        logic [`I2C_RD_LEN_W-1:0] rd_len;
        logic                     restart;
    } i2c_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic ack_err;
    } i2c_status_t;

    // SCL level plus one-cycle strobes at each quarter of the bit
    typedef struct packed {
        logic scl;
        logic fall;
        logic low_mid;
        logic rise;
        logic high_mid;
    } i2c_phase_t;

endpackage

// ==== hw/i2c_scl_gen.sv ====
`timescale 1ns/100ps

`include "i2c_master_params.svh"

module i2c_scl_gen
    import i2c_master_pkg::*;
(
    input  logic       i2c_clk,
    input  logic       rst_n,
    input  logic       run_i,
    output i2c_phase_t phase_o
);

    localparam int QW = $clog2(`I2C_QTR_DIV);

    logic [QW-1:0] qcnt_q;
    logic [1:0]    pcnt_q;
    logic          scl_q;
    logic          tick;

    // End of a quarter period
    assign tick = run_i && (qcnt_q == QW'(`I2C_QTR_DIV - 1));

    // Counters restart whenever run drops, so each transfer begins at a known phase
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            qcnt_q <= '0;
            pcnt_q <= 2'd0;
        end else if (!run_i) begin
            qcnt_q <= '0;
            pcnt_q <= 2'd0;
        end else if (tick) begin
            qcnt_q <= '0;
            pcnt_q <= pcnt_q + 2'd1;
        end else begin
            qcnt_q <= qcnt_q + 1'b1;
        end
    end

    // SCL moves one cycle after the fall and rise strobes
    // The level holds while run is low, so a held bus stays low
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= 1'b1;
        end else if (run_i && (qcnt_q == '0)) begin
            if (pcnt_q == 2'd1) begin
                scl_q <= 1'b0;
            end else if (pcnt_q == 2'd3) begin
                scl_q <= 1'b1;
            end
        end
    end

    assign phase_o.scl      = scl_q;
    assign phase_o.fall     = tick && (pcnt_q == 2'd0);
    assign phase_o.low_mid  = tick && (pcnt_q == 2'd1);
    assign phase_o.rise     = tick && (pcnt_q == 2'd2);
    assign phase_o.high_mid = tick && (pcnt_q == 2'd3);

endmodule

// ==== hw/i2c_byte_shifter.sv ====
`timescale 1ns/100ps

module i2c_byte_shifter (
    input  logic       i2c_clk,
    input  logic       rst_n,
    input  logic       load_i,
    input  logic [7:0] load_byte_i,
    input  logic       shift_en_i,
    input  logic       capture_en_i,
    input  logic       sda_i,
    output logic       tx_bit_o,
    output logic [7:0] rx_byte_o,
    output logic       last_bit_o
);

    logic [7:0] sreg_q;
    logic [2:0] cnt_q;

    // One register serves both directions; the bit count wraps after eight bits
    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            sreg_q <= 8'd0;
            cnt_q  <= 3'd0;
        end else if (load_i) begin
            sreg_q <= load_byte_i;
            cnt_q  <= 3'd0;
        end else if (shift_en_i || capture_en_i) begin
            sreg_q <= {sreg_q[6:0], sda_i};
            cnt_q  <= cnt_q + 3'd1;
        end
    end

    assign tx_bit_o   = sreg_q[7];
    assign rx_byte_o  = sreg_q;
    assign last_bit_o = (cnt_q == 3'd7);

endmodule

// ==== hw/i2c_master_fsm.sv ====
`timescale 1ns/100ps

`include "i2c_master_params.svh"

module i2c_master_fsm
    import i2c_master_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  i2c_cmd_t    cmd_i,
    input  i2c_phase_t  phase_i,
    input  logic        sda_i,
    input  logic        tx_bit_i,
    input  logic [7:0]  rx_byte_i,
    input  logic        last_bit_i,
    output logic        run_o,
    output logic        load_o,
    output logic [7:0]  load_byte_o,
    output logic        shift_en_o,
    output logic        capture_en_o,
    output logic        sda_o,
    output i2c_status_t status_o,
    output logic [7:0]  rdata_o,
    output logic        rdata_valid_o
);

    i2c_state_e               state_q;
    i2c_cmd_t                 cmd_q;
    logic [`I2C_RD_LEN_W-1:0] rem_q;
    logic                     sda_q;
    logic                     done_q;
    logic                     ack_err_q;
    logic                     accept;

    // A new command is taken only when the bus is ours and quiet
    assign accept = start_i && ((state_q == IDLE) || (state_q == HOLD));

    assign run_o = (state_q != IDLE) && (state_q != HOLD);

    // Address byte on accept, write byte once the address is acknowledged
    assign load_o = accept ||
                    ((state_q == ADDR_ACK) && phase_i.high_mid && !sda_i && !cmd_q.rw);
    assign load_byte_o = accept ? {cmd_i.addr, cmd_i.rw} : cmd_q.wdata;

    assign shift_en_o   = ((state_q == ADDR) || (state_q == WRITE)) && phase_i.high_mid;
    assign capture_en_o = (state_q == READ) && phase_i.high_mid;

    // Last bit is still on the bus, so it joins the byte here
    assign rdata_valid_o = capture_en_o && last_bit_i;
    assign rdata_o       = {rx_byte_i[6:0], sda_i};

    assign sda_o    = sda_q;
    assign status_o = '{busy: (state_q != IDLE), done: done_q, ack_err: ack_err_q};

    always_ff @(posedge i2c_clk) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
    end

    always_ff @(posedge i2c_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            rem_q     <= '0;
            sda_q     <= 1'b1;
            done_q    <= 1'b0;
            ack_err_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                state_q   <= START;
                rem_q     <= cmd_i.rd_len;
                ack_err_q <= 1'b0;
            end else begin
                case (state_q)
                    // After a hold, SCL is low at the first fall; wait a full bit
                    START: begin
                        if (phase_i.fall && phase_i.scl) begin
                            sda_q   <= 1'b0;
                            state_q <= ADDR;
                        end
                    end
                    ADDR, WRITE: begin
                        if (phase_i.low_mid) begin
                            sda_q <= tx_bit_i;
                        end
                        if (phase_i.high_mid && last_bit_i) begin
                            state_q <= (state_q == ADDR) ? ADDR_ACK : WRITE_ACK;
                        end
                    end
                    ADDR_ACK, WRITE_ACK: begin
                        if (phase_i.low_mid) begin
                            sda_q <= 1'b1;
                        end
                        if (phase_i.high_mid) begin
                            if (sda_i) begin
                                ack_err_q <= 1'b1;
                                state_q   <= STOP;
                            end else if (state_q == WRITE_ACK) begin
                                state_q <= STOP;
                            end else if (cmd_q.rw) begin
                                state_q <= READ;
                            end else begin
                                state_q <= WRITE;
                            end
                        end
                    end
                    READ: begin
                        if (phase_i.low_mid) begin
                            sda_q <= 1'b1;
                        end
                        if (phase_i.high_mid && last_bit_i) begin
                            state_q <= READ_ACK;
                        end
                    end
                    // ACK while bytes remain, NACK on the last one
                    READ_ACK: begin
                        if (phase_i.low_mid) begin
                            sda_q <= (rem_q == '0);
                        end
                        if (phase_i.high_mid) begin
                            if (rem_q != '0) begin
                                rem_q   <= rem_q - 1'b1;
                                state_q <= READ;
                            end else begin
                                state_q <= STOP;
                            end
                        end
                    end
                    STOP: begin
                        if (phase_i.low_mid) begin
                            if (cmd_q.restart) begin
                                state_q <= HOLD;
                                done_q  <= 1'b1;
                            end else begin
                                sda_q <= 1'b0;
                            end
                        end
                        if (phase_i.high_mid) begin
                            sda_q   <= 1'b1;
                            state_q <= IDLE;
                            done_q  <= 1'b1;
                        end
                    end
                    default: begin
                        state_q <= state_q;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/i2c_master_top.sv ====
`timescale 1ns/100ps

module i2c_master_top
    import i2c_master_pkg::*;
(
    input  logic        i2c_clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  i2c_cmd_t    cmd_i,
    input  logic        sda_i,
    output i2c_status_t status_o,
    output logic [7:0]  rdata_o,
    output logic        rdata_valid_o,
    output logic        scl_o,
    output logic        sda_o
);

    logic       run;
    i2c_phase_t phase;
    logic       load;
    logic [7:0] load_byte;
    logic       shift_en;
    logic       capture_en;
    logic       tx_bit;
    logic [7:0] rx_byte;
    logic       last_bit;

    i2c_scl_gen u_scl_gen (
        .i2c_clk (i2c_clk),
        .rst_n   (rst_n),
        .run_i   (run),
        .phase_o (phase)
    );

    i2c_byte_shifter u_shifter (
        .i2c_clk      (i2c_clk),
        .rst_n        (rst_n),
        .load_i       (load),
        .load_byte_i  (load_byte),
        .shift_en_i   (shift_en),
        .capture_en_i (capture_en),
        .sda_i        (sda_i),
        .tx_bit_o     (tx_bit),
        .rx_byte_o    (rx_byte),
        .last_bit_o   (last_bit)
    );

    i2c_master_fsm u_fsm (
        .i2c_clk       (i2c_clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .cmd_i         (cmd_i),
        .phase_i       (phase),
        .sda_i         (sda_i),
        .tx_bit_i      (tx_bit),
        .rx_byte_i     (rx_byte),
        .last_bit_i    (last_bit),
        .run_o         (run),
        .load_o        (load),
        .load_byte_o   (load_byte),
        .shift_en_o    (shift_en),
        .capture_en_o  (capture_en),
        .sda_o         (sda_o),
        .status_o      (status_o),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o)
    );

    // SCL is released when idle; during a hold it keeps the generator's low level
    assign scl_o = phase.scl | ~(run | status_o.busy);

endmodule

// ==== dv/i2c_slave_model.sv ====
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] SLV_ADDR = 7'h3c
) (
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_o,
    output int   ack_cnt_o,
    output int   nack_cnt_o
);

    typedef enum {S_IDLE, S_ADDR, S_ADDR_ACK, S_WR, S_WR_ACK, S_RD, S_RD_ACK} slv_state_e;

    slv_state_e state;
    logic [7:0] mem [16];
    logic [3:0] ptr;
    logic [7:0] shreg;
    logic [7:0] txreg;
    int         bit_cnt;
    logic       rw;
    logic       nack;

    initial begin
        // Every byte differs, so a wrong pointer shows up as wrong data
        for (int i = 0; i < 16; i++) begin
            mem[i] = {i[3:0], ~i[3:0]};
        end
        state      = S_IDLE;
        ptr        = 4'd0;
        shreg      = 8'd0;
        txreg      = 8'd0;
        bit_cnt    = 0;
        rw         = 1'b0;
        nack       = 1'b0;
        sda_o      = 1'b1;
        ack_cnt_o  = 0;
        nack_cnt_o = 0;
    end

    task automatic send_next_byte();
        txreg   = mem[ptr];
        ptr     = ptr + 4'd1;
        sda_o   = txreg[7];
        bit_cnt = 1;
        state   = S_RD;
    endtask

    // START or repeated START
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            state   = S_ADDR;
            bit_cnt = 0;
            sda_o   = 1'b1;
        end
    end

    // STOP
    always @(posedge sda_i) begin
        if (scl_i === 1'b1) begin
            state = S_IDLE;
            sda_o = 1'b1;
        end
    end

    // Sample on the rising SCL edge
    always @(posedge scl_i) begin
        case (state)
            S_ADDR, S_WR: begin
                shreg   = {shreg[6:0], sda_i};
                bit_cnt = bit_cnt + 1;
            end
            S_RD_ACK: begin
                nack = sda_i;
                if (sda_i) begin
                    nack_cnt_o++;
                end else begin
                    ack_cnt_o++;
                end
            end
            default: begin
            end
        endcase
    end

    // Drive on the falling SCL edge, while the line may change
    always @(negedge scl_i) begin
        case (state)
            S_ADDR: begin
                if (bit_cnt == 8) begin
                    if (shreg[7:1] == SLV_ADDR) begin
                        rw    = shreg[0];
                        sda_o = 1'b0;
                        state = S_ADDR_ACK;
                    end else begin
                        state = S_IDLE;
                    end
                end
            end
            S_ADDR_ACK, S_WR_ACK: begin
                if (rw) begin
                    send_next_byte();
                end else begin
                    sda_o   = 1'b1;
                    bit_cnt = 0;
                    state   = S_WR;
                end
            end
            S_WR: begin
                if (bit_cnt == 8) begin
                    mem[ptr] = shreg;
                    ptr      = ptr + 4'd1;
                    sda_o    = 1'b0;
                    state    = S_WR_ACK;
                end
            end
            S_RD: begin
                if (bit_cnt == 8) begin
                    sda_o = 1'b1;
                    state = S_RD_ACK;
                end else begin
                    sda_o   = txreg[7 - bit_cnt];
                    bit_cnt = bit_cnt + 1;
                end
            end
            // Master NACK ends the read and the line stays released
            S_RD_ACK: begin
                if (nack) begin
                    state = S_IDLE;
                end else begin
                    send_next_byte();
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/100ps

`include "i2c_master_params.svh"

module tb_i2c_master
    import i2c_master_pkg::*;
();

    localparam logic [6:0] SLV_ADDR = 7'h3c;
    localparam int N_CMD    = 40;
    localparam int CLK_NS   = 4;
    localparam int BIT_CYC  = 4 * `I2C_QTR_DIV;
    // Worst case is six bytes of nine bit periods, plus the idle gap
    localparam int XFER_CYC = 6 * 9 * BIT_CYC + 16;
    localparam int WD_CYC   = N_CMD * XFER_CYC + 1000;

    logic        i2c_clk;
    logic        rst_n;
    logic        start;
    i2c_cmd_t    cmd;
    i2c_status_t status;
    logic [7:0]  rdata;
    logic        rdata_valid;
    logic        scl;
    logic        dut_sda;
    logic        slv_sda;
    wire         sda_bus;
    int          slv_ack_cnt;
    int          slv_nack_cnt;
    integer      seed;
    int          err_cnt;
    int          start_cnt;
    int          stop_cnt;
    int          n_restart;
    logic [7:0]  model_mem [16];
    logic [3:0]  model_ptr;

    // Open-drain bus
    assign sda_bus = dut_sda & slv_sda;

    i2c_master_top dut0 (
        .i2c_clk       (i2c_clk),
        .rst_n         (rst_n),
        .start_i       (start),
        .cmd_i         (cmd),
        .sda_i         (sda_bus),
        .status_o      (status),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid),
        .scl_o         (scl),
        .sda_o         (dut_sda)
    );

    i2c_slave_model #(.SLV_ADDR(SLV_ADDR)) u_slave (
        .scl_i      (scl),
        .sda_i      (sda_bus),
        .sda_o      (slv_sda),
        .ack_cnt_o  (slv_ack_cnt),
        .nack_cnt_o (slv_nack_cnt)
    );

    always #(CLK_NS / 2) i2c_clk = ~i2c_clk;

    // Bus monitor for START and STOP conditions
    always @(negedge sda_bus) begin
        if (rst_n === 1'b1 && scl === 1'b1) begin
            start_cnt++;
        end
    end

    always @(posedge sda_bus) begin
        if (rst_n === 1'b1 && scl === 1'b1) begin
            stop_cnt++;
        end
    end

    initial begin
        #(WD_CYC * CLK_NS);
        $display("Timeout: the transfers did not complete in the expected time");
        $display("Regression failed");
        $finish;
    end

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("error: %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic i2c_cmd_t random_cmd(input logic last);
        i2c_cmd_t    c;
        logic [31:0] r;
        r = $random(seed);
        // Three commands in four go to the slave
        c.addr    = (r[1:0] != 2'b00) ? SLV_ADDR : (SLV_ADDR ^ (r[9:3] | 7'h01));
        c.rw      = r[10];
        c.wdata   = r[18:11];
        c.rd_len  = r[20 +: `I2C_RD_LEN_W];
        c.restart = !last && (r[24:23] == 2'b00);
        return c;
    endfunction

    // Bus quiet between transfers, or held low after a restart
    task automatic watch_gap(input logic held, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge i2c_clk);
            check_equal("busy", held, status.busy);
            check_equal("done", 0, status.done);
            check_equal("rdata_valid_o", 0, rdata_valid);
            check_equal("scl_o", held ? 0 : 1, scl);
            check_equal("sda_o", 1, dut_sda);
        end
    endtask

    task automatic run_transfer(input i2c_cmd_t c);
        logic match;
        int   exp_rd;
        int   n_rd;
        int   starts0;
        int   stops0;
        int   acks0;
        int   nacks0;
        match   = (c.addr == SLV_ADDR);
        exp_rd  = (match && c.rw) ? int'(c.rd_len) + 1 : 0;
        n_rd    = 0;
        starts0 = start_cnt;
        stops0  = stop_cnt;
        acks0   = slv_ack_cnt;
        nacks0  = slv_nack_cnt;
        @(posedge i2c_clk);
        #1;
        cmd   = c;
        start = 1'b1;
        @(posedge i2c_clk);
        #1;
        start = 1'b0;
        cmd   = '0;
        @(negedge i2c_clk);
        check_equal("busy", 1, status.busy);
        while (status.done !== 1'b1) begin
            if (rdata_valid === 1'b1) begin
                if (n_rd < exp_rd) begin
                    check_equal("rdata_o", model_mem[model_ptr], rdata);
                    model_ptr++;
                end
                n_rd++;
            end
            @(negedge i2c_clk);
        end
        check_equal("ack_err", !match, status.ack_err);
        check_equal("rdata_valid_o pulses", exp_rd, n_rd);
        check_equal("START count", starts0 + 1, start_cnt);
        check_equal("STOP count", stops0 + (c.restart ? 0 : 1), stop_cnt);
        // Every read byte but the last is acknowledged
        check_equal("slave ACK count", acks0 + ((exp_rd > 0) ? exp_rd - 1 : 0), slv_ack_cnt);
        check_equal("slave NACK count", nacks0 + ((exp_rd > 0) ? 1 : 0), slv_nack_cnt);
        if (match && !c.rw) begin
            model_mem[model_ptr] = c.wdata;
            model_ptr++;
        end
    endtask

    initial begin
        i2c_cmd_t c;
        int       gap;
        i2c_clk   = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        cmd       = '0;
        seed      = 95;
        err_cnt   = 0;
        start_cnt = 0;
        stop_cnt  = 0;
        n_restart = 0;
        model_ptr = 4'd0;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = {i[3:0], ~i[3:0]};
        end
        repeat (10) @(posedge i2c_clk);
        #1;
        rst_n = 1'b1;
        @(negedge i2c_clk);
        check_equal("ack_err", 0, status.ack_err);
        watch_gap(1'b0, 4);
        for (int n = 0; n < N_CMD; n++) begin
            c = random_cmd(n == N_CMD - 1);
            if (c.restart) begin
                n_restart++;
            end
            run_transfer(c);
            gap = 2 + ($random(seed) & 7);
            watch_gap(c.restart, gap);
        end
        check_equal("total START count", N_CMD, start_cnt);
        check_equal("total STOP count", N_CMD - n_restart, stop_cnt);
        $display("Closing: %0d errors over %0d commands, %0d START, %0d STOP",
                 err_cnt, N_CMD, start_cnt, stop_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== i2c_master.f ====
+incdir+hw
hw/i2c_master_pkg.sv
hw/i2c_scl_gen.sv
hw/i2c_byte_shifter.sv
hw/i2c_master_fsm.sv
hw/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - include_dirs:
      - hw
    files:
      - hw/i2c_master_pkg.sv
      - hw/i2c_scl_gen.sv
      - hw/i2c_byte_shifter.sv
      - hw/i2c_master_fsm.sv
      - hw/i2c_master_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/i2c_slave_model.sv
      - dv/tb_i2c_master.sv
